//--- logic/nrisc_isa_pkg.sv
// 16-bit ISA encoding. Call, return and stack codes are absent and decode as NOP
`default_nettype none

package nrisc_isa_pkg;

  typedef logic [15:0] instr_t;   // Raw instruction word
  typedef logic [3:0]  reg_idx_t; // Register file index
  typedef logic [7:0]  imm8_t;    // Channel or immediate byte
  typedef logic [2:0]  flags_t;   // ALU flags {minus, zero, carry}

  localparam int IS_ALU_BIT = 15; // Set for all ALU operations

  // Bit positions inside flags_t
  localparam int FLAG_C = 0;
  localparam int FLAG_Z = 1;
  localparam int FLAG_M = 2;

  // Non-ALU classes in bits 14:12
  localparam logic [2:0] CLS_CTRL  = 3'd0;
  localparam logic [2:0] CLS_JUMP  = 3'd1;
  localparam logic [2:0] CLS_LOAD  = 3'd2;
  localparam logic [2:0] CLS_STORE = 3'd3;
  localparam logic [2:0] CLS_LDI   = 3'd4;

  // Control sub-codes in bits 10:8
  localparam logic [2:0] SUB_STATE = 3'd0;
  localparam logic [2:0] SUB_MODE  = 3'd1;
  localparam logic [2:0] SUB_SIE   = 3'd2;
  localparam logic [2:0] SUB_SID   = 3'd3;

  localparam imm8_t STATE_HALT  = 8'd1;
  localparam imm8_t STATE_WAIT  = 8'd2;
  localparam imm8_t STATE_SLEEP = 8'd3;
  localparam imm8_t MODE_GIE    = 8'd0; // Global interrupt enable
  localparam imm8_t MODE_GID    = 8'd1; // Global interrupt disable

  localparam reg_idx_t R_PC = 4'd1; // Program counter lives in R1

  // Jump kind in bits 11:10, condition in bits 9:8
  localparam logic [1:0] JMP_ABS     = 2'd0;
  localparam logic [1:0] JMP_REL     = 2'd1;
  localparam logic [1:0] JMP_IREL    = 2'd2; // Codes 8 to B
  localparam logic [1:0] COND_ALWAYS = 2'd0;
  localparam logic [1:0] COND_ZERO   = 2'd1;
  localparam logic [1:0] COND_MINUS  = 2'd2;
  localparam logic [1:0] COND_CARRY  = 2'd3;

  // Load codes in bits 3:0
  localparam logic [3:0] LD_MOVE  = 4'd0;
  localparam logic [3:0] LD_WORD  = 4'd1;
  localparam logic [3:0] LD_SBYTE = 4'd2;
  localparam logic [3:0] LD_UBYTE = 4'd3;
  localparam logic [3:0] LD_SHALF = 4'd4;
  localparam logic [3:0] LD_UHALF = 4'd5;

  // Store kind in bits 11:10
  localparam logic [1:0] ST_BYTE = 2'd0;
  localparam logic [1:0] ST_HALF = 2'd1;
  localparam logic [1:0] ST_WORD = 2'd2;

  // ALU groups where bit 11 picks the operation instead of the immediate
  localparam logic [2:0] ALU_GRP_AND = 3'd2;
  localparam logic [2:0] ALU_GRP_OR  = 3'd3;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_AND  = 4'h2,
    ALU_NAND = 4'h3,
    ALU_OR   = 4'h4,
    ALU_XOR  = 4'h6,
    ALU_SHLR = 4'h8,
    ALU_SHAR = 4'hA,
    ALU_SHL  = 4'hC,
    ALU_ROT  = 4'hE
  } alu_op_e;

endpackage

`default_nettype wire

//--- logic/nrisc_ctrl_pkg.sv
// Control word encodings. Mode RUN is only reached through reset
`default_nettype none

package nrisc_ctrl_pkg;

  typedef enum logic [1:0] {
    BSEL_REG   = 2'd0, // Operand B from rf2
    BSEL_IMM_U = 2'd2, // Zero-extended immediate
    BSEL_IMM_S = 2'd3  // Sign-extended immediate
  } b_sel_e;

  typedef logic [2:0] mem_size_t;

  // Load sizes
  localparam mem_size_t MSZ_LD_WORD  = 3'd0;
  localparam mem_size_t MSZ_LD_UBYTE = 3'd1;
  localparam mem_size_t MSZ_LD_UHALF = 3'd2;
  localparam mem_size_t MSZ_LD_SBYTE = 3'd5;
  localparam mem_size_t MSZ_LD_SHALF = 3'd6;

  // Byte and half store codes carry the lane number below the prefix
  localparam logic       MSZ_ST_BYTE_PFX = 1'b0;
  localparam logic [1:0] MSZ_ST_HALF_PFX = 2'b10;
  localparam mem_size_t  MSZ_ST_WORD     = 3'd7;

  typedef enum logic [1:0] {
    INT_NONE    = 2'd0,
    INT_ENABLE  = 2'd1,
    INT_DISABLE = 2'd2
  } int_ctrl_e;

  typedef enum logic [1:0] {
    MODE_RUN   = 2'd0,
    MODE_WAIT  = 2'd1,
    MODE_SLEEP = 2'd2,
    MODE_HALT  = 2'd3
  } core_mode_e;

endpackage

`default_nettype wire

//--- logic/nrisc_dec_if.sv
// Internal streams of the decoder. Valid and payload must hold while ready is low
`default_nettype none

interface instr_if;
  logic                  valid;
  logic                  ready;
  nrisc_isa_pkg::instr_t instr;
  nrisc_isa_pkg::flags_t flags; // Flags sampled with the instruction

  modport src (output valid, instr, flags, input ready);
  modport dst (input valid, instr, flags, output ready);
endinterface

interface ctrl_if;
  logic                       valid;
  logic                       ready;
  nrisc_isa_pkg::alu_op_e     alu_op;
  nrisc_ctrl_pkg::b_sel_e     b_sel;
  nrisc_isa_pkg::reg_idx_t    rd;
  nrisc_isa_pkg::reg_idx_t    rf1;
  nrisc_isa_pkg::reg_idx_t    rf2;
  logic                       reg_write;
  logic                       mem_load;
  logic                       mem_write;
  nrisc_ctrl_pkg::mem_size_t  mem_size;
  logic                       wb_from_mem;   // Writeback from data memory
  logic                       addr_from_reg; // Address from rf1 not ALU
  logic                       pc_take;
  nrisc_ctrl_pkg::int_ctrl_e  int_ctrl;
  nrisc_isa_pkg::imm8_t       int_channel;
  nrisc_ctrl_pkg::core_mode_e mode_req;      // RUN means no change
  logic                       gie_wr;
  logic                       gie_val;

  modport src (output valid, alu_op, b_sel, rd, rf1, rf2, reg_write, mem_load,
               mem_write, mem_size, wb_from_mem, addr_from_reg, pc_take,
               int_ctrl, int_channel, mode_req, gie_wr, gie_val, input ready);
  modport dst (input valid, alu_op, b_sel, rd, rf1, rf2, reg_write, mem_load,
               mem_write, mem_size, wb_from_mem, addr_from_reg, pc_take,
               int_ctrl, int_channel, mode_req, gie_wr, gie_val, output ready);
endinterface

`default_nettype wire

//--- logic/nrisc_intake.sv
// One-entry input buffer. in_ready depends combinationally on downstream ready
`default_nettype none

module nrisc_intake (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  in_valid,
  input  wire nrisc_isa_pkg::instr_t in_instr,
  input  wire nrisc_isa_pkg::flags_t in_flags,
  output      logic                  in_ready,
  instr_if.src                       inst
);

  logic                  full;    // Holds an item
  nrisc_isa_pkg::instr_t instr_q;
  nrisc_isa_pkg::flags_t flags_q;

  assign in_ready = !full || inst.ready; // Empty or item leaving

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
    end else if (in_ready) begin
      full <= in_valid; // Refill or drain
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      instr_q <= in_instr;
      flags_q <= in_flags; // Branch flags frozen at acceptance
    end
  end

  assign inst.valid = full;
  assign inst.instr = instr_q;
  assign inst.flags = flags_q;

endmodule

`default_nettype wire

//--- logic/nrisc_field_decode.sv
// Pure combinational decode. Unused and dropped encodings give a NOP word
`default_nettype none

module nrisc_field_decode (
  instr_if.dst inst,
  ctrl_if.src  ctrl
);

  nrisc_isa_pkg::instr_t ins;
  nrisc_isa_pkg::flags_t flg;

  assign ins = inst.instr;
  assign flg = inst.flags;

  assign ctrl.valid = inst.valid; // Handshake passes straight through
  assign inst.ready = ctrl.ready;

  always_comb begin
    // NOP defaults
    ctrl.alu_op        = nrisc_isa_pkg::ALU_ADD;
    ctrl.b_sel         = nrisc_ctrl_pkg::BSEL_REG;
    ctrl.rd            = '0;
    ctrl.rf1           = '0;
    ctrl.rf2           = '0;
    ctrl.reg_write     = 1'b0;
    ctrl.mem_load      = 1'b0;
    ctrl.mem_write     = 1'b0;
    ctrl.mem_size      = nrisc_ctrl_pkg::MSZ_LD_WORD;
    ctrl.wb_from_mem   = 1'b0;
    ctrl.addr_from_reg = 1'b0;
    ctrl.pc_take       = 1'b0;
    ctrl.int_ctrl      = nrisc_ctrl_pkg::INT_NONE;
    ctrl.int_channel   = '0;
    ctrl.mode_req      = nrisc_ctrl_pkg::MODE_RUN;
    ctrl.gie_wr        = 1'b0;
    ctrl.gie_val       = 1'b0;

    if (ins[nrisc_isa_pkg::IS_ALU_BIT]) begin
      ctrl.rd        = {1'b1, ins[10:8]}; // Upper register bank only
      ctrl.rf1       = ins[7:4];
      ctrl.rf2       = ins[3:0];
      ctrl.reg_write = 1'b1;
      if (ins[11] && ins[14:12] != nrisc_isa_pkg::ALU_GRP_AND &&
          ins[14:12] != nrisc_isa_pkg::ALU_GRP_OR) begin
        ctrl.b_sel = nrisc_ctrl_pkg::BSEL_IMM_U;
      end
      case (ins[14:12])
        3'd0: ctrl.alu_op = nrisc_isa_pkg::ALU_ADD;
        3'd1: ctrl.alu_op = nrisc_isa_pkg::ALU_SUB;
        3'd2: ctrl.alu_op = ins[11] ? nrisc_isa_pkg::ALU_NAND : nrisc_isa_pkg::ALU_AND;
        3'd3: ctrl.alu_op = ins[11] ? nrisc_isa_pkg::ALU_XOR : nrisc_isa_pkg::ALU_OR;
        3'd4: ctrl.alu_op = nrisc_isa_pkg::ALU_SHLR;
        3'd5: ctrl.alu_op = nrisc_isa_pkg::ALU_SHAR;
        3'd6: ctrl.alu_op = nrisc_isa_pkg::ALU_SHL;
        default: ctrl.alu_op = nrisc_isa_pkg::ALU_ROT;
      endcase
    end else begin
      case (ins[14:12])
        nrisc_isa_pkg::CLS_LOAD: begin
          ctrl.rd  = ins[11:8];
          ctrl.rf1 = ins[7:4]; // rf2 stays R0 so the sum is rf1
          ctrl.reg_write = (ins[3:0] <= nrisc_isa_pkg::LD_UHALF); // Codes 6 to F are NOP
          ctrl.mem_load    = ctrl.reg_write && (ins[3:0] != nrisc_isa_pkg::LD_MOVE);
          ctrl.wb_from_mem = ctrl.mem_load;
          case (ins[3:0])
            nrisc_isa_pkg::LD_SBYTE: ctrl.mem_size = nrisc_ctrl_pkg::MSZ_LD_SBYTE;
            nrisc_isa_pkg::LD_UBYTE: ctrl.mem_size = nrisc_ctrl_pkg::MSZ_LD_UBYTE;
            nrisc_isa_pkg::LD_SHALF: ctrl.mem_size = nrisc_ctrl_pkg::MSZ_LD_SHALF;
            nrisc_isa_pkg::LD_UHALF: ctrl.mem_size = nrisc_ctrl_pkg::MSZ_LD_UHALF;
            default:                 ctrl.mem_size = nrisc_ctrl_pkg::MSZ_LD_WORD;
          endcase
        end
        nrisc_isa_pkg::CLS_STORE: begin
          ctrl.rf1 = ins[7:4]; // Address
          ctrl.rf2 = ins[3:0]; // Data
          ctrl.mem_write     = (ins[11:10] != 2'd3);
          ctrl.addr_from_reg = ctrl.mem_write;
          case (ins[11:10])
            nrisc_isa_pkg::ST_BYTE:
              ctrl.mem_size = {nrisc_ctrl_pkg::MSZ_ST_BYTE_PFX, ins[9:8]};
            nrisc_isa_pkg::ST_HALF:
              ctrl.mem_size = {nrisc_ctrl_pkg::MSZ_ST_HALF_PFX, ins[8]};
            default: ctrl.mem_size = nrisc_ctrl_pkg::MSZ_ST_WORD;
          endcase
        end
        nrisc_isa_pkg::CLS_LDI: begin
          ctrl.rd        = ins[11:8];
          ctrl.reg_write = 1'b1; // R0 plus immediate
          ctrl.b_sel     = ins[11] ? nrisc_ctrl_pkg::BSEL_IMM_S : nrisc_ctrl_pkg::BSEL_IMM_U;
        end
        nrisc_isa_pkg::CLS_JUMP: begin
          ctrl.rf2 = ins[3:0];
          ctrl.rf1 = (ins[11:10] == nrisc_isa_pkg::JMP_ABS) ? ins[7:4] : nrisc_isa_pkg::R_PC;
          if (ins[11:10] == nrisc_isa_pkg::JMP_IREL) begin
            ctrl.b_sel = nrisc_ctrl_pkg::BSEL_IMM_S;
          end
          if (ins[11:10] != 2'd3) begin // Codes C to F are NOP
            case (ins[9:8])
              nrisc_isa_pkg::COND_ALWAYS: ctrl.pc_take = 1'b1;
              nrisc_isa_pkg::COND_ZERO:   ctrl.pc_take = flg[nrisc_isa_pkg::FLAG_Z];
              nrisc_isa_pkg::COND_MINUS:  ctrl.pc_take = flg[nrisc_isa_pkg::FLAG_M];
              default:                    ctrl.pc_take = flg[nrisc_isa_pkg::FLAG_C];
            endcase
          end
        end
        nrisc_isa_pkg::CLS_CTRL: begin
          if (!ins[11]) begin // Bit 11 set was call and return
            case (ins[10:8])
              nrisc_isa_pkg::SUB_STATE: begin
                case (ins[7:0])
                  nrisc_isa_pkg::STATE_HALT:  ctrl.mode_req = nrisc_ctrl_pkg::MODE_HALT;
                  nrisc_isa_pkg::STATE_WAIT:  ctrl.mode_req = nrisc_ctrl_pkg::MODE_WAIT;
                  nrisc_isa_pkg::STATE_SLEEP: ctrl.mode_req = nrisc_ctrl_pkg::MODE_SLEEP;
                  default:                    ctrl.mode_req = nrisc_ctrl_pkg::MODE_RUN;
                endcase
              end
              nrisc_isa_pkg::SUB_MODE: begin
                ctrl.gie_wr  = (ins[7:0] == nrisc_isa_pkg::MODE_GIE) ||
                               (ins[7:0] == nrisc_isa_pkg::MODE_GID);
                ctrl.gie_val = (ins[7:0] == nrisc_isa_pkg::MODE_GIE);
              end
              nrisc_isa_pkg::SUB_SIE: begin
                ctrl.int_ctrl    = nrisc_ctrl_pkg::INT_ENABLE;
                ctrl.int_channel = ins[7:0];
              end
              nrisc_isa_pkg::SUB_SID: begin
                ctrl.int_ctrl    = nrisc_ctrl_pkg::INT_DISABLE;
                ctrl.int_channel = ins[7:0];
              end
              default: ctrl.int_ctrl = nrisc_ctrl_pkg::INT_NONE;
            endcase
          end
        end
        default: ctrl.int_ctrl = nrisc_ctrl_pkg::INT_NONE; // Classes 5 to 7 unused
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/nrisc_issue.sv
// Output stage. Stall flags compare only against the word issued just before
`default_nettype none

module nrisc_issue (
  input  wire logic                        clk,
  input  wire logic                        arst_n,
  input  wire logic                        ctrl_ready,
  ctrl_if.dst                              ctrl,
  output      logic                        ctrl_valid,
  output      logic                        stall_a,
  output      logic                        stall_b,
  output      nrisc_ctrl_pkg::core_mode_e  core_mode,
  output      logic                        gie,
  output      nrisc_isa_pkg::alu_op_e      alu_op,
  output      nrisc_ctrl_pkg::b_sel_e      b_sel,
  output      nrisc_isa_pkg::reg_idx_t     rd,
  output      nrisc_isa_pkg::reg_idx_t     rf1,
  output      nrisc_isa_pkg::reg_idx_t     rf2,
  output      logic                        reg_write,
  output      logic                        mem_load,
  output      logic                        mem_write,
  output      nrisc_ctrl_pkg::mem_size_t   mem_size,
  output      logic                        wb_from_mem,
  output      logic                        addr_from_reg,
  output      logic                        pc_take,
  output      nrisc_ctrl_pkg::int_ctrl_e   int_ctrl,
  output      nrisc_isa_pkg::imm8_t        int_channel
);

  logic take; // Word accepted this cycle

  assign ctrl.ready = !ctrl_valid || ctrl_ready;
  assign take       = ctrl.valid && ctrl.ready;

  // rd and reg_write still hold the previously issued word
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_valid <= 1'b0;
      reg_write  <= 1'b0;
      mem_load   <= 1'b0;
      mem_write  <= 1'b0;
      pc_take    <= 1'b0;
      int_ctrl   <= nrisc_ctrl_pkg::INT_NONE;
      stall_a    <= 1'b0;
      stall_b    <= 1'b0;
      core_mode  <= nrisc_ctrl_pkg::MODE_RUN;
      gie        <= 1'b0;
    end else begin
      if (ctrl.ready) begin
        ctrl_valid <= ctrl.valid; // Load new or drain
      end
      if (take) begin
        reg_write <= ctrl.reg_write;
        mem_load  <= ctrl.mem_load;
        mem_write <= ctrl.mem_write;
        pc_take   <= ctrl.pc_take;
        int_ctrl  <= ctrl.int_ctrl;
        stall_a   <= reg_write && (ctrl.rf1 == rd); // RAW on operand A
        stall_b   <= reg_write && (ctrl.rf2 == rd); // RAW on operand B
        if (ctrl.mode_req != nrisc_ctrl_pkg::MODE_RUN) begin
          core_mode <= ctrl.mode_req;
        end
        if (ctrl.gie_wr) begin
          gie <= ctrl.gie_val;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      alu_op        <= ctrl.alu_op;
      b_sel         <= ctrl.b_sel;
      rd            <= ctrl.rd;
      rf1           <= ctrl.rf1;
      rf2           <= ctrl.rf2;
      mem_size      <= ctrl.mem_size;
      wb_from_mem   <= ctrl.wb_from_mem;
      addr_from_reg <= ctrl.addr_from_reg;
      int_channel   <= ctrl.int_channel;
    end
  end

endmodule

`default_nettype wire

//--- logic/nrisc_decoder_top.sv
// Decoder top. Two cycles of buffering and a combinational ctrl_ready to in_ready path
`default_nettype none

module nrisc_decoder_top (
  input  wire logic                        clk,
  input  wire logic                        arst_n,
  input  wire logic                        in_valid,
  output      logic                        in_ready,
  input  wire nrisc_isa_pkg::instr_t       in_instr,
  input  wire nrisc_isa_pkg::flags_t       in_flags,
  output      logic                        ctrl_valid,
  input  wire logic                        ctrl_ready,
  output      nrisc_isa_pkg::alu_op_e      alu_op,
  output      nrisc_ctrl_pkg::b_sel_e      b_sel,
  output      nrisc_isa_pkg::reg_idx_t     rd,
  output      nrisc_isa_pkg::reg_idx_t     rf1,
  output      nrisc_isa_pkg::reg_idx_t     rf2,
  output      logic                        reg_write,
  output      logic                        mem_load,
  output      logic                        mem_write,
  output      nrisc_ctrl_pkg::mem_size_t   mem_size,
  output      logic                        wb_from_mem,
  output      logic                        addr_from_reg,
  output      logic                        pc_take,
  output      logic                        stall_a,
  output      logic                        stall_b,
  output      nrisc_ctrl_pkg::int_ctrl_e   int_ctrl,
  output      nrisc_isa_pkg::imm8_t        int_channel,
  output      nrisc_ctrl_pkg::core_mode_e  core_mode,
  output      logic                        gie
);

  instr_if u_instr_if ();
  ctrl_if  u_ctrl_if ();

  nrisc_intake u_intake (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_flags (in_flags),
    .in_ready (in_ready),
    .inst     (u_instr_if.src)
  );

  nrisc_field_decode u_decode (
    .inst (u_instr_if.dst),
    .ctrl (u_ctrl_if.src)
  );

  nrisc_issue u_issue (
    .clk           (clk),
    .arst_n        (arst_n),
    .ctrl_ready    (ctrl_ready),
    .ctrl          (u_ctrl_if.dst),
    .ctrl_valid    (ctrl_valid),
    .stall_a       (stall_a),
    .stall_b       (stall_b),
    .core_mode     (core_mode),
    .gie           (gie),
    .alu_op        (alu_op),
    .b_sel         (b_sel),
    .rd            (rd),
    .rf1           (rf1),
    .rf2           (rf2),
    .reg_write     (reg_write),
    .mem_load      (mem_load),
    .mem_write     (mem_write),
    .mem_size      (mem_size),
    .wb_from_mem   (wb_from_mem),
    .addr_from_reg (addr_from_reg),
    .pc_take       (pc_take),
    .int_ctrl      (int_ctrl),
    .int_channel   (int_channel)
  );

endmodule

`default_nettype wire

//--- testbench/nrisc_decoder_tb.sv
// Must run from the project root to find testbench/decode_cases.txt. Holds up to 64 cases
`default_nettype none

module nrisc_decoder_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CASES  = 64;
  localparam int IDLE_LIMIT = 64; // Cycles without progress before giving up

  logic                       clk;
  logic                       arst_n;
  logic                       in_valid;
  logic                       in_ready;
  nrisc_isa_pkg::instr_t      in_instr;
  nrisc_isa_pkg::flags_t      in_flags;
  logic                       ctrl_valid;
  logic                       ctrl_ready;
  nrisc_isa_pkg::alu_op_e     alu_op;
  nrisc_ctrl_pkg::b_sel_e     b_sel;
  nrisc_isa_pkg::reg_idx_t    rd;
  nrisc_isa_pkg::reg_idx_t    rf1;
  nrisc_isa_pkg::reg_idx_t    rf2;
  logic                       reg_write;
  logic                       mem_load;
  logic                       mem_write;
  nrisc_ctrl_pkg::mem_size_t  mem_size;
  logic                       wb_from_mem;
  logic                       addr_from_reg;
  logic                       pc_take;
  logic                       stall_a;
  logic                       stall_b;
  nrisc_ctrl_pkg::int_ctrl_e  int_ctrl;
  nrisc_isa_pkg::imm8_t       int_channel;
  nrisc_ctrl_pkg::core_mode_e core_mode;
  logic                       gie;

  string       names [MAX_CASES];
  logic [15:0] cases [MAX_CASES][18]; // Columns of the cases file after the name
  int          n_cases;
  int          errors;
  integer      seed;

  nrisc_decoder_top DUT (
    .clk (clk), .arst_n (arst_n),
    .in_valid (in_valid), .in_ready (in_ready), .in_instr (in_instr), .in_flags (in_flags),
    .ctrl_valid (ctrl_valid), .ctrl_ready (ctrl_ready),
    .alu_op (alu_op), .b_sel (b_sel), .rd (rd), .rf1 (rf1), .rf2 (rf2),
    .reg_write (reg_write), .mem_load (mem_load), .mem_write (mem_write),
    .mem_size (mem_size), .wb_from_mem (wb_from_mem), .addr_from_reg (addr_from_reg),
    .pc_take (pc_take), .stall_a (stall_a), .stall_b (stall_b),
    .int_ctrl (int_ctrl), .int_channel (int_channel), .core_mode (core_mode), .gie (gie)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  task automatic load_cases();
    int          fd;
    int          cnt;
    string       line;
    string       nm;
    logic [15:0] fld [18];
    fd = $fopen("testbench/decode_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/decode_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && n_cases < MAX_CASES) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue; // Blank or column notes
      cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", nm,
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
                    fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
                    fld[17]);
      if (cnt != 19) begin
        $display("Malformed line in the cases file, %0d fields read", cnt);
        errors++;
      end else begin
        names[n_cases] = nm;
        for (int i = 0; i < 18; i++) begin
          cases[n_cases][i] = fld[i];
        end
        n_cases++;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_field(input string name, input string field,
                             input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp) else begin
      $display("Fail %s %s: expected %0h, actual %0h", name, field, exp, act);
      errors++;
    end
  endtask

  task automatic check_item(input int idx);
    string nm;
    nm = names[idx];
    check_field(nm, "alu_op", cases[idx][2], alu_op);
    check_field(nm, "b_sel", cases[idx][3], b_sel);
    check_field(nm, "rd", cases[idx][4], rd);
    check_field(nm, "rf1", cases[idx][5], rf1);
    check_field(nm, "rf2", cases[idx][6], rf2);
    check_field(nm, "reg_write", cases[idx][7], reg_write);
    check_field(nm, "mem_load", cases[idx][8], mem_load);
    check_field(nm, "wb_from_mem", cases[idx][8], wb_from_mem);     // Loads write back memory
    check_field(nm, "mem_write", cases[idx][9], mem_write);
    check_field(nm, "addr_from_reg", cases[idx][9], addr_from_reg); // Stores address from rf1
    check_field(nm, "mem_size", cases[idx][10], mem_size);
    check_field(nm, "pc_take", cases[idx][11], pc_take);
    check_field(nm, "stall_a", cases[idx][12], stall_a);
    check_field(nm, "stall_b", cases[idx][13], stall_b);
    check_field(nm, "int_ctrl", cases[idx][14], int_ctrl);
    check_field(nm, "int_channel", cases[idx][15], int_channel);
    check_field(nm, "core_mode", cases[idx][16], core_mode);
    check_field(nm, "gie", cases[idx][17], gie);
  endtask

  initial begin
    int in_idx;
    int out_idx;
    int in_idle;
    int out_idle;
    bit timed_out;
    errors = 0;
    n_cases = 0;
    seed = 32'hec8c;
    arst_n = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    in_flags = '0;
    ctrl_ready = 1'b0;
    in_idx = 0;
    out_idx = 0;
    in_idle = 0;
    out_idle = 0;
    timed_out = 1'b0;
    load_cases();
    assert (n_cases > 0) else begin
      $display("No cases were read from the cases file");
      errors++;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_field("reset", "ctrl_valid", 0, ctrl_valid);
    check_field("reset", "in_ready", 1, in_ready);
    check_field("reset", "reg_write", 0, reg_write);
    check_field("reset", "mem_load", 0, mem_load);
    check_field("reset", "mem_write", 0, mem_write);
    check_field("reset", "pc_take", 0, pc_take);
    check_field("reset", "int_ctrl", 0, int_ctrl);
    check_field("reset", "core_mode", 0, core_mode);
    check_field("reset", "gie", 0, gie);
    arst_n = 1'b1;

    while (out_idx < n_cases && !timed_out) begin
      @(negedge clk);
      ctrl_ready = ($random(seed) & 3) != 0; // Low about one cycle in four
      if (in_idx < n_cases) begin
        in_valid = 1'b1;
        in_instr = cases[in_idx][0];
        in_flags = cases[in_idx][1][2:0];
      end else begin
        in_valid = 1'b0;
      end
      #1; // in_ready follows ctrl_ready combinationally
      if (ctrl_valid && ctrl_ready) begin
        check_item(out_idx); // Item leaves at the next rising edge
        out_idx++;
        out_idle = 0;
      end else begin
        out_idle++;
      end
      if (in_valid && in_ready) begin
        in_idx++;
        in_idle = 0;
      end else if (in_valid) begin
        in_idle++;
      end
      assert (out_idle <= IDLE_LIMIT && in_idle <= IDLE_LIMIT) else begin
        $display("Timeout, no progress for %0d cycles (in_ready or ctrl_valid stuck low)",
                 IDLE_LIMIT);
        errors++;
        timed_out = 1'b1;
      end
    end

    if (!timed_out) begin
      ctrl_ready = 1'b1;
      in_valid = 1'b0;
      repeat (4) begin
        @(negedge clk);
        assert (ctrl_valid === 1'b0) else begin
          $display("An extra item appeared at the output after the last case");
          errors++;
        end
      end
    end

    $display("Errors: %0d, items checked: %0d of %0d", errors, out_idx, n_cases);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/decode_cases.txt
# name instr flags alu_op b_sel rd rf1 rf2 reg_write mem_load mem_write mem_size pc_take
# then stall_a stall_b int_ctrl int_channel core_mode gie, all numbers in hex
add_r 8234 0 0 0 a 3 4 1 0 0 0 0 0 0 0 00 0 0
add_i 8ba5 0 0 2 b a 5 1 0 0 0 0 1 0 0 00 0 0
sub_r 941b 0 1 0 c 1 b 1 0 0 0 0 0 1 0 00 0 0
sub_i 9d23 0 1 2 d 2 3 1 0 0 0 0 0 0 0 00 0 0
and_r a6dd 0 2 0 e d d 1 0 0 0 0 1 1 0 00 0 0
nand_r af45 0 3 0 f 4 5 1 0 0 0 0 0 0 0 00 0 0
or_r b067 0 4 0 8 6 7 1 0 0 0 0 0 0 0 00 0 0
xor_r b982 0 6 0 9 8 2 1 0 0 0 0 1 0 0 00 0 0
shlr_r c234 0 8 0 a 3 4 1 0 0 0 0 0 0 0 00 0 0
shlr_i cb12 0 8 2 b 1 2 1 0 0 0 0 0 0 0 00 0 0
shar_r d435 0 a 0 c 3 5 1 0 0 0 0 0 0 0 00 0 0
shar_i dd67 0 a 2 d 6 7 1 0 0 0 0 0 0 0 00 0 0
shl_r e612 0 c 0 e 1 2 1 0 0 0 0 0 0 0 00 0 0
shl_i ef34 0 c 2 f 3 4 1 0 0 0 0 0 0 0 00 0 0
rot_r f056 0 e 0 8 5 6 1 0 0 0 0 0 0 0 00 0 0
rot_i f976 0 e 2 9 7 6 1 0 0 0 0 0 0 0 00 0 0
move 2390 0 0 0 3 9 0 1 0 0 0 0 1 0 0 00 0 0
ld_word 2431 0 0 0 4 3 0 1 1 0 0 0 1 0 0 00 0 0
ld_sbyte 2562 0 0 0 5 6 0 1 1 0 5 0 0 0 0 00 0 0
ld_ubyte 2673 0 0 0 6 7 0 1 1 0 1 0 0 0 0 00 0 0
ld_shalf 2784 0 0 0 7 8 0 1 1 0 6 0 0 0 0 00 0 0
ld_uhalf 2275 0 0 0 2 7 0 1 1 0 2 0 1 0 0 00 0 0
st_byte3 3312 0 0 0 0 1 2 0 0 1 3 0 0 1 0 00 0 0
st_half1 3545 0 0 0 0 4 5 0 0 1 5 0 0 0 0 00 0 0
st_word 3867 0 0 0 0 6 7 0 0 1 7 0 0 0 0 00 0 0
ldi_u 457f 0 0 2 5 0 0 1 0 0 0 0 0 0 0 00 0 0
ldi_s 4a80 0 0 3 a 0 0 1 0 0 0 0 0 0 0 00 0 0
jabs_always 10a3 0 0 0 0 a 3 0 0 0 0 1 1 0 0 00 0 0
jabs_zero_set 1140 2 0 0 0 4 0 0 0 0 0 1 0 0 0 00 0 0
jabs_zero_clr 1140 5 0 0 0 4 0 0 0 0 0 0 0 0 0 00 0 0
jrel_minus_set 1602 4 0 0 0 1 2 0 0 0 0 1 0 0 0 00 0 0
jrel_minus_clr 1602 3 0 0 0 1 2 0 0 0 0 0 0 0 0 00 0 0
jirel_carry_set 1b00 1 0 3 0 1 0 0 0 0 0 1 0 0 0 00 0 0
jirel_carry_clr 1b00 6 0 3 0 1 0 0 0 0 0 0 0 0 0 00 0 0
gie 0100 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 0 1
sie 0235 0 0 0 0 0 0 0 0 0 0 0 0 0 1 35 0 1
halt 0001 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 3 1
add_hold 8234 0 0 0 a 3 4 1 0 0 0 0 0 0 0 00 3 1
wait 0002 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 1 1
sleep 0003 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 2 1
sid 0335 0 0 0 0 0 0 0 0 0 0 0 0 0 2 35 2 1
gid 0101 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 2 0
nop_call 0800 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 2 0

//--- files.f
logic/nrisc_isa_pkg.sv
logic/nrisc_ctrl_pkg.sv
logic/nrisc_dec_if.sv
logic/nrisc_intake.sv
logic/nrisc_field_decode.sv
logic/nrisc_issue.sv
logic/nrisc_decoder_top.sv
testbench/nrisc_decoder_tb.sv

//--- Bender.yml
package:
  name: nrisc_decoder

sources:
  - logic/nrisc_isa_pkg.sv
  - logic/nrisc_ctrl_pkg.sv
  - logic/nrisc_dec_if.sv
  - logic/nrisc_intake.sv
  - logic/nrisc_field_decode.sv
  - logic/nrisc_issue.sv
  - logic/nrisc_decoder_top.sv
  - target: test
    files:
      - testbench/nrisc_decoder_tb.sv
